//--- rf_subsystem.f
src/rf_pkg.sv
src/rf_pipe_if.sv
src/rf_dpram.sv
src/rf_write_port.sv
src/rf_operand_bypass.sv
src/rf_spr_readback.sv
src/rf_subsystem.sv
verif/rf_subsystem_tb.sv

//--- src/rf_dpram.sv
`timescale 1ns/1ps

module rf_dpram import rf_pkg::*; (
   input  logic                     clk,
   input  logic [RF_ADDR_WIDTH-1:0] raddr_i,
   input  logic                     re_i,
   input  logic [RF_ADDR_WIDTH-1:0] waddr_i,
   input  logic                     we_i,
   input  logic [OPERAND_WIDTH-1:0] wdat_i,
   output logic [OPERAND_WIDTH-1:0] rdat_o
);

   logic [OPERAND_WIDTH-1:0] mem [RF_WORDS];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdat_i;
      end
   end

   // Read data holds while re_i is low; a same-cycle write is not seen
   always_ff @(posedge clk) begin
      if (re_i) begin
         rdat_o <= mem[raddr_i];
      end
   end

endmodule

//--- src/rf_operand_bypass.sv
`timescale 1ns/1ps

module rf_operand_bypass import rf_pkg::*; (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     padv_decode_i,
   input  logic                     decode_valid_i,
   input  logic                     fetch_rf_adr_valid_i,
   input  logic [RF_ADDR_WIDTH-1:0] fetch_rfa_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0] fetch_rfb_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0] decode_rfa_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0] decode_rfb_adr_i,
   input  logic                     pipeline_flush_i,
   input  logic [OPERAND_WIDTH-1:0] result_i,
   input  logic [OPERAND_WIDTH-1:0] ctrl_alu_result_i,
   rf_pipe_if.bypass_mp             pipe,
   input  logic                     rf_wren_i,
   input  logic [RF_ADDR_WIDTH-1:0] rf_wradr_i,
   input  logic [OPERAND_WIDTH-1:0] rf_wrdat_i,
   output logic [OPERAND_WIDTH-1:0] decode_rfa_o,
   output logic [OPERAND_WIDTH-1:0] decode_rfb_o,
   output logic [OPERAND_WIDTH-1:0] execute_rfa_o,
   output logic [OPERAND_WIDTH-1:0] execute_rfb_o
);

   // Index 0 is operand A, index 1 is operand B
   logic [RF_ADDR_WIDTH-1:0] fetch_adr [2];
   logic [RF_ADDR_WIDTH-1:0] decode_adr [2];
   logic [OPERAND_WIDTH-1:0] ram_dat [2];
   logic [OPERAND_WIDTH-1:0] decode_opr [2];
   logic [OPERAND_WIDTH-1:0] execute_opr [2];
   logic [OPERAND_WIDTH-1:0] execute_q [2];
   logic [OPERAND_WIDTH-1:0] wb_to_dec_result [2];

   logic       flushing;
   logic [1:0] exe_hazard;
   logic [1:0] ctrl_hazard;
   logic [1:0] wb_hazard;
   logic [1:0] use_last_wb;
   logic [1:0] wb_to_dec_bypass;

   logic [OPERAND_WIDTH-1:0] exe_result_q;
   logic [OPERAND_WIDTH-1:0] exe_result;
   logic [OPERAND_WIDTH-1:0] ctrl_result_q;
   logic [OPERAND_WIDTH-1:0] ctrl_result;
   logic [OPERAND_WIDTH-1:0] wb_hazard_result;

   assign fetch_adr[0]  = fetch_rfa_adr_i;
   assign fetch_adr[1]  = fetch_rfb_adr_i;
   assign decode_adr[0] = decode_rfa_adr_i;
   assign decode_adr[1] = decode_rfb_adr_i;

   rf_dpram rfa (
      .clk     (clk),
      .raddr_i (fetch_rfa_adr_i),
      .re_i    (fetch_rf_adr_valid_i),
      .waddr_i (rf_wradr_i),
      .we_i    (rf_wren_i),
      .wdat_i  (rf_wrdat_i),
      .rdat_o  (ram_dat[0])
   );

   rf_dpram rfb (
      .clk     (clk),
      .raddr_i (fetch_rfb_adr_i),
      .re_i    (fetch_rf_adr_valid_i),
      .waddr_i (rf_wradr_i),
      .we_i    (rf_wren_i),
      .wdat_i  (rf_wrdat_i),
      .rdat_o  (ram_dat[1])
   );

   // Hazard flags, sampled when decode advances into execute
   always_ff @(posedge clk) begin
      if (rst) begin
         flushing    <= 1'b0;
         exe_hazard  <= '0;
         ctrl_hazard <= '0;
         wb_hazard   <= '0;
      end else begin
         // Execute stage content is invalid after a flush until decode advances
         if (pipeline_flush_i) begin
            flushing <= 1'b1;
         end else if (padv_decode_i) begin
            flushing <= 1'b0;
         end
         for (int p = 0; p < 2; p++) begin
            if (pipeline_flush_i) begin
               exe_hazard[p] <= 1'b0;
            end else if (padv_decode_i && !flushing) begin
               exe_hazard[p] <= pipe.execute_rf_wb &
                                (pipe.execute_rfd_adr == decode_adr[p]);
            end
            if (padv_decode_i) begin
               ctrl_hazard[p] <= pipe.ctrl_rf_wb & (pipe.ctrl_rfd_adr == decode_adr[p]);
               wb_hazard[p]   <= pipe.wb_rf_wb & (pipe.wb_rfd_adr == decode_adr[p]);
            end
         end
      end
   end

   // Decode reads no RAM after fetch, so writebacks to its registers are kept
   always_ff @(posedge clk) begin
      if (rst) begin
         use_last_wb      <= '0;
         wb_to_dec_bypass <= '0;
      end else begin
         for (int p = 0; p < 2; p++) begin
            if (fetch_rf_adr_valid_i) begin
               wb_to_dec_bypass[p] <= pipe.wb_rf_wb & (pipe.wb_rfd_adr == fetch_adr[p]);
               use_last_wb[p]      <= 1'b0;
            end else if (pipe.wb_rf_wb && (pipe.wb_rfd_adr == decode_adr[p])) begin
               use_last_wb[p] <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (decode_valid_i) begin
         exe_result_q  <= ctrl_alu_result_i;
         ctrl_result_q <= result_i;
      end
      if (padv_decode_i) begin
         wb_hazard_result <= result_i;
      end
      for (int p = 0; p < 2; p++) begin
         if (padv_decode_i) begin
            execute_q[p] <= decode_opr[p];
         end
         if (fetch_rf_adr_valid_i ||
             (pipe.wb_rf_wb && (pipe.wb_rfd_adr == decode_adr[p]))) begin
            wb_to_dec_result[p] <= result_i;
         end
      end
   end

   // Live results while the producing stage still holds its instruction
   assign exe_result  = decode_valid_i ? ctrl_alu_result_i : exe_result_q;
   assign ctrl_result = decode_valid_i ? result_i : ctrl_result_q;

   always_comb begin
      for (int p = 0; p < 2; p++) begin
         if (pipe.ctrl_rf_wb && (pipe.ctrl_rfd_adr == decode_adr[p])) begin
            decode_opr[p] = ctrl_alu_result_i;
         end else if (use_last_wb[p]) begin
            decode_opr[p] = wb_to_dec_result[p];
         end else if (pipe.wb_rf_wb && (pipe.wb_rfd_adr == decode_adr[p])) begin
            decode_opr[p] = result_i;
         end else if (wb_to_dec_bypass[p]) begin
            decode_opr[p] = wb_to_dec_result[p];
         end else begin
            decode_opr[p] = ram_dat[p];
         end

         if (exe_hazard[p]) begin
            execute_opr[p] = exe_result;
         end else if (ctrl_hazard[p]) begin
            execute_opr[p] = ctrl_result;
         end else if (wb_hazard[p]) begin
            execute_opr[p] = wb_hazard_result;
         end else begin
            execute_opr[p] = execute_q[p];
         end
      end
   end

   assign decode_rfa_o  = decode_opr[0];
   assign decode_rfb_o  = decode_opr[1];
   assign execute_rfa_o = execute_opr[0];
   assign execute_rfb_o = execute_opr[1];

endmodule

//--- src/rf_pipe_if.sv
`timescale 1ns/1ps

interface rf_pipe_if import rf_pkg::*; ();

   // Destination register numbers per stage
   logic [RF_ADDR_WIDTH-1:0] execute_rfd_adr;
   logic [RF_ADDR_WIDTH-1:0] ctrl_rfd_adr;
   logic [RF_ADDR_WIDTH-1:0] wb_rfd_adr;

   // Register write flags per stage
   logic                     execute_rf_wb;
   logic                     ctrl_rf_wb;
   logic                     wb_rf_wb;

   modport src (
      output execute_rfd_adr, ctrl_rfd_adr, wb_rfd_adr,
      output execute_rf_wb, ctrl_rf_wb, wb_rf_wb
   );

   modport bypass_mp (
      input execute_rfd_adr, ctrl_rfd_adr, wb_rfd_adr,
      input execute_rf_wb, ctrl_rf_wb, wb_rf_wb
   );

   // Write port only cares about the writeback stage
   modport wb_mp (
      input wb_rfd_adr, wb_rf_wb
   );

endinterface

//--- src/rf_pkg.sv
package rf_pkg;

   // Datapath and register file geometry
   localparam int OPERAND_WIDTH  = 32;
   localparam int RF_ADDR_WIDTH  = 5;
   localparam int RF_WORDS       = 32;

   // Debug bus address space
   localparam int SPR_ADDR_WIDTH = 16;
   localparam logic [6:0] SPR_GPR_GROUP = 7'd2;

   // Group view of a debug address, group in the top seven bits
   typedef struct packed {
      logic [6:0]               grp;
      logic [3:0]               rsvd;
      logic [RF_ADDR_WIDTH-1:0] idx;
   } spr_addr_fields_t;

   // The same address word seen flat or split into fields
   typedef union packed {
      logic [SPR_ADDR_WIDTH-1:0] flat;
      spr_addr_fields_t          f;
   } spr_addr_u;

endpackage

//--- src/rf_spr_readback.sv
`timescale 1ns/1ps

module rf_spr_readback import rf_pkg::*; (
   input  logic                     clk,
   input  logic                     rst,
   input  spr_addr_u                spr_addr_i,
   input  logic                     spr_rd_req_i,
   input  logic                     spr_wr_ack_i,
   input  logic                     rf_wren_i,
   input  logic [RF_ADDR_WIDTH-1:0] rf_wradr_i,
   input  logic [OPERAND_WIDTH-1:0] rf_wrdat_i,
   output logic                     spr_ack_o,
   output logic [OPERAND_WIDTH-1:0] spr_dat_o
);

   logic spr_rd_req_q;

   // Dedicated copy so debug reads never disturb the fetch ports
   rf_dpram rfspr (
      .clk     (clk),
      .raddr_i (spr_addr_i.f.idx),
      .re_i    (1'b1),
      .waddr_i (rf_wradr_i),
      .we_i    (rf_wren_i),
      .wdat_i  (rf_wrdat_i),
      .rdat_o  (spr_dat_o)
   );

   // RAM output lags the address by a cycle, hence the two-cycle read
   always_ff @(posedge clk) begin
      if (rst) begin
         spr_rd_req_q <= 1'b0;
      end else begin
         spr_rd_req_q <= spr_rd_req_i;
      end
   end

   assign spr_ack_o = spr_wr_ack_i | (spr_rd_req_i & spr_rd_req_q);

endmodule

//--- src/rf_subsystem.sv
`timescale 1ns/1ps

module rf_subsystem import rf_pkg::*; (
   input  logic                      clk,
   input  logic                      rst,

   // Pipeline control
   input  logic                      padv_decode_i,
   input  logic                      padv_ctrl_i,
   input  logic                      decode_valid_i,
   input  logic                      fetch_rf_adr_valid_i,
   input  logic                      pipeline_flush_i,

   // Register numbers
   input  logic [RF_ADDR_WIDTH-1:0]  fetch_rfa_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0]  fetch_rfb_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0]  decode_rfa_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0]  decode_rfb_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0]  execute_rfd_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0]  ctrl_rfd_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0]  wb_rfd_adr_i,

   // Write flags and results
   input  logic                      execute_rf_wb_i,
   input  logic                      ctrl_rf_wb_i,
   input  logic                      wb_rf_wb_i,
   input  logic [OPERAND_WIDTH-1:0]  result_i,
   input  logic [OPERAND_WIDTH-1:0]  ctrl_alu_result_i,

   // Debug bus
   input  logic [SPR_ADDR_WIDTH-1:0] spr_addr_i,
   input  logic                      spr_stb_i,
   input  logic                      spr_we_i,
   input  logic [OPERAND_WIDTH-1:0]  spr_dat_i,
   output logic                      spr_ack_o,
   output logic [OPERAND_WIDTH-1:0]  spr_dat_o,

   output logic [OPERAND_WIDTH-1:0]  decode_rfa_o,
   output logic [OPERAND_WIDTH-1:0]  decode_rfb_o,
   output logic [OPERAND_WIDTH-1:0]  execute_rfa_o,
   output logic [OPERAND_WIDTH-1:0]  execute_rfb_o
);

   spr_addr_u                spr_addr;
   logic                     rf_wren;
   logic [RF_ADDR_WIDTH-1:0] rf_wradr;
   logic [OPERAND_WIDTH-1:0] rf_wrdat;
   logic                     spr_wr_ack;
   logic                     spr_rd_req;

   rf_pipe_if pipe ();

   assign spr_addr.flat = spr_addr_i;

   assign pipe.execute_rfd_adr = execute_rfd_adr_i;
   assign pipe.ctrl_rfd_adr    = ctrl_rfd_adr_i;
   assign pipe.wb_rfd_adr      = wb_rfd_adr_i;
   assign pipe.execute_rf_wb   = execute_rf_wb_i;
   assign pipe.ctrl_rf_wb      = ctrl_rf_wb_i;
   assign pipe.wb_rf_wb        = wb_rf_wb_i;

   rf_write_port u_write_port (
      .clk          (clk),
      .rst          (rst),
      .spr_addr_i   (spr_addr),
      .spr_stb_i    (spr_stb_i),
      .spr_we_i     (spr_we_i),
      .spr_dat_i    (spr_dat_i),
      .padv_ctrl_i  (padv_ctrl_i),
      .result_i     (result_i),
      .wb           (pipe.wb_mp),
      .rf_wren_o    (rf_wren),
      .rf_wradr_o   (rf_wradr),
      .rf_wrdat_o   (rf_wrdat),
      .spr_wr_ack_o (spr_wr_ack),
      .spr_rd_req_o (spr_rd_req)
   );

   rf_operand_bypass u_operand_bypass (
      .clk                  (clk),
      .rst                  (rst),
      .padv_decode_i        (padv_decode_i),
      .decode_valid_i       (decode_valid_i),
      .fetch_rf_adr_valid_i (fetch_rf_adr_valid_i),
      .fetch_rfa_adr_i      (fetch_rfa_adr_i),
      .fetch_rfb_adr_i      (fetch_rfb_adr_i),
      .decode_rfa_adr_i     (decode_rfa_adr_i),
      .decode_rfb_adr_i     (decode_rfb_adr_i),
      .pipeline_flush_i     (pipeline_flush_i),
      .result_i             (result_i),
      .ctrl_alu_result_i    (ctrl_alu_result_i),
      .pipe                 (pipe.bypass_mp),
      .rf_wren_i            (rf_wren),
      .rf_wradr_i           (rf_wradr),
      .rf_wrdat_i           (rf_wrdat),
      .decode_rfa_o         (decode_rfa_o),
      .decode_rfb_o         (decode_rfb_o),
      .execute_rfa_o        (execute_rfa_o),
      .execute_rfb_o        (execute_rfb_o)
   );

   rf_spr_readback u_spr_readback (
      .clk          (clk),
      .rst          (rst),
      .spr_addr_i   (spr_addr),
      .spr_rd_req_i (spr_rd_req),
      .spr_wr_ack_i (spr_wr_ack),
      .rf_wren_i    (rf_wren),
      .rf_wradr_i   (rf_wradr),
      .rf_wrdat_i   (rf_wrdat),
      .spr_ack_o    (spr_ack_o),
      .spr_dat_o    (spr_dat_o)
   );

endmodule

//--- src/rf_write_port.sv
`timescale 1ns/1ps

module rf_write_port import rf_pkg::*; (
   input  logic                     clk,
   input  logic                     rst,
   input  spr_addr_u                spr_addr_i,
   input  logic                     spr_stb_i,
   input  logic                     spr_we_i,
   input  logic [OPERAND_WIDTH-1:0] spr_dat_i,
   input  logic                     padv_ctrl_i,
   input  logic [OPERAND_WIDTH-1:0] result_i,
   rf_pipe_if.wb_mp                 wb,
   output logic                     rf_wren_o,
   output logic [RF_ADDR_WIDTH-1:0] rf_wradr_o,
   output logic [OPERAND_WIDTH-1:0] rf_wrdat_o,
   output logic                     spr_wr_ack_o,
   output logic                     spr_rd_req_o
);

   logic spr_gpr_hit;
   logic spr_wr_req;
   logic spr_wr_take;
   logic spr_wr_done_q;

   // Debug access that falls into the register group
   assign spr_gpr_hit = (spr_addr_i.f.grp == SPR_GPR_GROUP);

   // One write per strobe assertion, so the ack stays a single pulse
   assign spr_wr_req   = spr_gpr_hit & spr_stb_i & spr_we_i & ~spr_wr_done_q;
   assign spr_rd_req_o = spr_gpr_hit & spr_stb_i & ~spr_we_i & ~padv_ctrl_i;

   // Writeback wins, the debug write waits for a free cycle
   assign spr_wr_take  = spr_wr_req & ~wb.wb_rf_wb;
   assign spr_wr_ack_o = spr_wr_take;

   always_ff @(posedge clk) begin
      if (rst) begin
         spr_wr_done_q <= 1'b0;
      end else if (!spr_stb_i) begin
         spr_wr_done_q <= 1'b0;
      end else if (spr_wr_take) begin
         spr_wr_done_q <= 1'b1;
      end
   end

   // Shared RAM write bus
   assign rf_wren_o  = wb.wb_rf_wb | spr_wr_req;
   assign rf_wradr_o = wb.wb_rf_wb ? wb.wb_rfd_adr : spr_addr_i.f.idx;
   assign rf_wrdat_o = wb.wb_rf_wb ? result_i : spr_dat_i;

endmodule

//--- verif/rf_subsystem_tb.sv
`timescale 1ns/1ps

module rf_subsystem_tb import rf_pkg::*; ();

   localparam int          CLK_PERIOD = 8;
   localparam int unsigned SEED       = 32'h8572a272;
   localparam int          RAND_PAIRS = 24;
   localparam int          ITER       = 8;
   localparam int          ACK_WAIT   = 8;
   // Cycles of tests 1 to 6 in order, plus reset and the closing cycles of each test
   localparam int TEST_CYCLES = 4 + (RF_WORDS + 1 + 2 * RAND_PAIRS) + ITER * 7 + ITER * 4
                                + ITER * 9 + ITER * 4 + ITER * (3 * ACK_WAIT + 10) + 6 * 2;
   localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * CLK_PERIOD;

   logic                      clk;
   logic                      rst;
   logic                      padv_decode_i, padv_ctrl_i, decode_valid_i;
   logic                      fetch_rf_adr_valid_i, pipeline_flush_i;
   logic [RF_ADDR_WIDTH-1:0]  fetch_rfa_adr_i, fetch_rfb_adr_i;
   logic [RF_ADDR_WIDTH-1:0]  decode_rfa_adr_i, decode_rfb_adr_i;
   logic [RF_ADDR_WIDTH-1:0]  execute_rfd_adr_i, ctrl_rfd_adr_i, wb_rfd_adr_i;
   logic                      execute_rf_wb_i, ctrl_rf_wb_i, wb_rf_wb_i;
   logic [OPERAND_WIDTH-1:0]  result_i, ctrl_alu_result_i;
   logic [SPR_ADDR_WIDTH-1:0] spr_addr_i;
   logic                      spr_stb_i, spr_we_i;
   logic [OPERAND_WIDTH-1:0]  spr_dat_i;
   logic                      spr_ack_o;
   logic [OPERAND_WIDTH-1:0]  spr_dat_o;
   logic [OPERAND_WIDTH-1:0]  decode_rfa_o, decode_rfb_o, execute_rfa_o, execute_rfb_o;

   // Register model and the expected operands of the current cycle
   logic [OPERAND_WIDTH-1:0]  model [RF_WORDS];
   logic                      dec_chk, exe_chk;
   logic [OPERAND_WIDTH-1:0]  exp_dec_a, exp_dec_b, exp_exe_a, exp_exe_b;
   spr_addr_u                 spr_view;
   logic                      gpr_hit;
   logic                      rd_sel;
   int                        errors = 0;
   int                        err_base = 0;
   int                        tests_run = 0;

   rf_subsystem i_dut (.*);

   assign spr_view.flat = spr_addr_i;
   assign gpr_hit       = (spr_view.f.grp == SPR_GPR_GROUP);
   assign rd_sel        = spr_stb_i && !spr_we_i && gpr_hit && !padv_ctrl_i;

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic void log_error(input string msg);
      errors++;
      $display("** Error @%0t: %s", $time, msg);
   endfunction

   function automatic logic [SPR_ADDR_WIDTH-1:0] gpr_spr_addr(input logic [4:0] idx);
      return {SPR_GPR_GROUP, 4'b0000, idx};
   endfunction

   // Ctrl stage result wins over every other decode source
   ctrl_fwd_a: assert property (@(posedge clk) disable iff (rst)
      ctrl_rf_wb_i && ctrl_rfd_adr_i == decode_rfa_adr_i |-> decode_rfa_o == ctrl_alu_result_i)
      else log_error("decode operand A misses the ctrl result");
   ctrl_fwd_b: assert property (@(posedge clk) disable iff (rst)
      ctrl_rf_wb_i && ctrl_rfd_adr_i == decode_rfb_adr_i |-> decode_rfb_o == ctrl_alu_result_i)
      else log_error("decode operand B misses the ctrl result");
   decode_ok: assert property (@(posedge clk) disable iff (rst)
      dec_chk |-> decode_rfa_o == exp_dec_a && decode_rfb_o == exp_dec_b)
      else log_error($sformatf("decode operands %h %h, expected %h %h",
         $sampled(decode_rfa_o), $sampled(decode_rfb_o), $sampled(exp_dec_a),
         $sampled(exp_dec_b)));
   execute_ok: assert property (@(posedge clk) disable iff (rst)
      exe_chk |-> execute_rfa_o == exp_exe_a && execute_rfb_o == exp_exe_b)
      else log_error($sformatf("execute operands %h %h, expected %h %h",
         $sampled(execute_rfa_o), $sampled(execute_rfb_o), $sampled(exp_exe_a),
         $sampled(exp_exe_b)));
   wr_ack: assert property (@(posedge clk) disable iff (rst)
      spr_stb_i && spr_we_i && gpr_hit && !wb_rf_wb_i |-> spr_ack_o)
      else log_error("free debug write not acked in its cycle");
   wr_blocked: assert property (@(posedge clk) disable iff (rst)
      spr_stb_i && spr_we_i && wb_rf_wb_i |-> !spr_ack_o)
      else log_error("debug write acked during a writeback");
   foreign_group: assert property (@(posedge clk) disable iff (rst)
      spr_stb_i && !gpr_hit |-> !spr_ack_o)
      else log_error("debug access outside the register group acked");
   rd_ack: assert property (@(posedge clk) disable iff (rst)
      rd_sel && $past(rd_sel) && $stable(spr_addr_i)
      |-> spr_ack_o && spr_dat_o == model[spr_view.f.idx])
      else log_error($sformatf("debug read ack %b data %h, expected %h", $sampled(spr_ack_o),
         $sampled(spr_dat_o), $sampled(model[spr_view.f.idx])));
   // A read is only acked once the request has been seen in two cycles
   rd_early: assert property (@(posedge clk) disable iff (rst)
      spr_stb_i && !spr_we_i && !(rd_sel && $past(rd_sel)) |-> !spr_ack_o)
      else log_error("debug read acked before its second cycle");

   // Model follows every accepted write, writeback first
   always @(posedge clk) begin
      if (!rst) begin
         if (wb_rf_wb_i) begin
            model[wb_rfd_adr_i] <= result_i;
         end else if (spr_stb_i && spr_we_i && gpr_hit) begin
            model[spr_view.f.idx] <= spr_dat_i;
         end
      end
   end

   task automatic clear_controls();
      padv_decode_i        <= 1'b0;
      padv_ctrl_i          <= 1'b0;
      decode_valid_i       <= 1'b0;
      fetch_rf_adr_valid_i <= 1'b0;
      pipeline_flush_i     <= 1'b0;
      execute_rf_wb_i      <= 1'b0;
      ctrl_rf_wb_i         <= 1'b0;
      wb_rf_wb_i           <= 1'b0;
      spr_stb_i            <= 1'b0;
      spr_we_i             <= 1'b0;
      dec_chk              <= 1'b0;
      exe_chk              <= 1'b0;
   endtask

   task automatic fetch_cycle(input logic [4:0] a, input logic [4:0] b);
      @(posedge clk);
      clear_controls();
      fetch_rf_adr_valid_i <= 1'b1;
      fetch_rfa_adr_i      <= a;
      fetch_rfb_adr_i      <= b;
   endtask

   task automatic decode_cycle(input logic [4:0] a, input logic [4:0] b,
                               input logic [31:0] ea, input logic [31:0] eb);
      @(posedge clk);
      clear_controls();
      decode_rfa_adr_i <= a;
      decode_rfb_adr_i <= b;
      dec_chk          <= 1'b1;
      exp_dec_a        <= ea;
      exp_dec_b        <= eb;
   endtask

   task automatic expect_execute(input logic [31:0] ea, input logic [31:0] eb);
      @(posedge clk);
      clear_controls();
      exe_chk   <= 1'b1;
      exp_exe_a <= ea;
      exp_exe_b <= eb;
   endtask

   task automatic wait_ack(input string what);
      int n;
      n = 0;
      @(posedge clk);
      while (!spr_ack_o && n < ACK_WAIT) begin
         @(posedge clk);
         n++;
      end
      if (!spr_ack_o) begin
         errors++;
         $display("At %0t ns the %s was never acknowledged", $time, what);
      end
      spr_stb_i <= 1'b0;
      spr_we_i  <= 1'b0;
   endtask

   task automatic finish_test(input string name);
      @(posedge clk);
      clear_controls();
      @(posedge clk);
      tests_run++;
      $display("Test %0d (%s) finished with %0d errors", tests_run, name, errors - err_base);
      err_base = errors;
   endtask

   task automatic test_ram_path();
      logic [4:0] a;
      logic [4:0] b;
      for (int r = 0; r < RF_WORDS; r++) begin
         @(posedge clk);
         clear_controls();
         wb_rf_wb_i   <= 1'b1;
         wb_rfd_adr_i <= RF_ADDR_WIDTH'(r);
         result_i     <= $urandom();
      end
      @(posedge clk);
      clear_controls();
      for (int n = 0; n < RAND_PAIRS; n++) begin
         a = RF_ADDR_WIDTH'($urandom());
         b = RF_ADDR_WIDTH'($urandom());
         fetch_cycle(a, b);
         decode_cycle(a, b, model[a], model[b]);
      end
      finish_test("ram path");
   endtask

   task automatic test_wb_to_decode();
      logic [4:0]  a;
      logic [4:0]  b;
      logic [31:0] v;
      logic [31:0] w;
      for (int n = 0; n < ITER; n++) begin
         a = RF_ADDR_WIDTH'($urandom());
         b = a ^ 5'd16;
         v = $urandom();
         w = $urandom();
         // Writeback in the fetch cycle, seen live and then captured
         fetch_cycle(a, b);
         wb_rf_wb_i   <= 1'b1;
         wb_rfd_adr_i <= a;
         result_i     <= v;
         decode_cycle(a, b, v, model[b]);
         decode_cycle(a, b, v, model[b]);
         result_i <= ~v;
         // Writeback while decode holds B
         fetch_cycle(a, b);
         decode_cycle(a, b, v, w);
         wb_rf_wb_i   <= 1'b1;
         wb_rfd_adr_i <= b;
         result_i     <= w;
         decode_cycle(a, b, v, w);
         result_i <= ~w;
      end
      finish_test("writeback to decode");
   endtask

   task automatic test_ctrl_to_decode();
      logic [4:0]  a;
      logic [4:0]  b;
      logic [31:0] c;
      logic [31:0] v;
      for (int n = 0; n < ITER; n++) begin
         a = RF_ADDR_WIDTH'($urandom());
         b = a ^ 5'd4;
         c = $urandom();
         v = $urandom();
         fetch_cycle(a, b);
         decode_cycle(a, b, c, model[b]);
         ctrl_rf_wb_i      <= 1'b1;
         ctrl_rfd_adr_i    <= a;
         ctrl_alu_result_i <= c;
         wb_rf_wb_i        <= 1'b1;
         wb_rfd_adr_i      <= a;
         result_i          <= v;
         // Ctrl moves to B, A falls back to the held writeback
         decode_cycle(a, b, v, ~c);
         ctrl_rf_wb_i      <= 1'b1;
         ctrl_rfd_adr_i    <= b;
         ctrl_alu_result_i <= ~c;
      end
      finish_test("ctrl to decode");
   endtask

   task automatic test_execute();
      logic [4:0]  a;
      logic [4:0]  b;
      logic [31:0] ma;
      logic [31:0] mb;
      logic [31:0] x;
      for (int n = 0; n < ITER; n++) begin
         a  = RF_ADDR_WIDTH'($urandom());
         b  = a ^ 5'd8;
         ma = model[a];
         mb = model[b];
         x  = $urandom();
         fetch_cycle(a, b);
         decode_cycle(a, b, ma, mb);
         padv_decode_i <= 1'b1;
         expect_execute(ma, mb);
         // Execute stage writes A at the advance
         fetch_cycle(a, b);
         decode_cycle(a, b, ma, mb);
         padv_decode_i     <= 1'b1;
         execute_rf_wb_i   <= 1'b1;
         execute_rfd_adr_i <= a;
         expect_execute(x, mb);
         decode_valid_i    <= 1'b1;
         ctrl_alu_result_i <= x;
         expect_execute(x, mb);
         ctrl_alu_result_i <= ~x;
      end
      finish_test("execute operands");
   endtask

   task automatic test_flush();
      logic [4:0]  a;
      logic [4:0]  b;
      logic [31:0] ma;
      logic [31:0] mb;
      for (int n = 0; n < ITER; n++) begin
         a  = RF_ADDR_WIDTH'($urandom());
         b  = a ^ 5'd2;
         ma = model[a];
         mb = model[b];
         fetch_cycle(a, b);
         decode_cycle(a, b, ma, mb);
         pipeline_flush_i <= 1'b1;
         decode_cycle(a, b, ma, mb);
         padv_decode_i     <= 1'b1;
         execute_rf_wb_i   <= 1'b1;
         execute_rfd_adr_i <= a;
         expect_execute(ma, mb);
         decode_valid_i    <= 1'b1;
         ctrl_alu_result_i <= ~ma;
      end
      finish_test("flush");
   endtask

   task automatic test_debug_port();
      logic [4:0] idx;
      for (int n = 0; n < ITER; n++) begin
         idx = RF_ADDR_WIDTH'($urandom());
         @(posedge clk);
         clear_controls();
         spr_addr_i <= gpr_spr_addr(idx);
         spr_stb_i  <= 1'b1;
         spr_we_i   <= 1'b1;
         spr_dat_i  <= $urandom();
         wait_ack("debug write");
         // Write that meets a writeback waits two cycles
         @(posedge clk);
         clear_controls();
         spr_addr_i   <= gpr_spr_addr(idx ^ 5'd3);
         spr_stb_i    <= 1'b1;
         spr_we_i     <= 1'b1;
         spr_dat_i    <= $urandom();
         wb_rf_wb_i   <= 1'b1;
         wb_rfd_adr_i <= idx ^ 5'd1;
         result_i     <= $urandom();
         repeat (2) @(posedge clk);
         wb_rf_wb_i <= 1'b0;
         wait_ack("debug write after a writeback");
         // Read held back one cycle by a ctrl advance
         @(posedge clk);
         clear_controls();
         spr_addr_i  <= gpr_spr_addr(idx);
         spr_stb_i   <= 1'b1;
         padv_ctrl_i <= 1'b1;
         @(posedge clk);
         padv_ctrl_i <= 1'b0;
         wait_ack("debug read");
         @(posedge clk);
         clear_controls();
         spr_addr_i <= {7'd3, 4'd0, idx};
         spr_stb_i  <= 1'b1;
         spr_we_i   <= n[0];
         repeat (3) @(posedge clk);
      end
      finish_test("debug port");
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      void'($urandom(SEED));
      rst                  = 1'b1;
      padv_decode_i        = 1'b0;
      padv_ctrl_i          = 1'b0;
      decode_valid_i       = 1'b0;
      fetch_rf_adr_valid_i = 1'b0;
      pipeline_flush_i     = 1'b0;
      fetch_rfa_adr_i      = '0;
      fetch_rfb_adr_i      = '0;
      decode_rfa_adr_i     = '0;
      decode_rfb_adr_i     = '0;
      execute_rfd_adr_i    = '0;
      ctrl_rfd_adr_i       = '0;
      wb_rfd_adr_i         = '0;
      execute_rf_wb_i      = 1'b0;
      ctrl_rf_wb_i         = 1'b0;
      wb_rf_wb_i           = 1'b0;
      result_i             = '0;
      ctrl_alu_result_i    = '0;
      spr_addr_i           = '0;
      spr_stb_i            = 1'b0;
      spr_we_i             = 1'b0;
      spr_dat_i            = '0;
      dec_chk              = 1'b0;
      exe_chk              = 1'b0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      test_ram_path();
      test_wb_to_decode();
      test_ctrl_to_decode();
      test_execute();
      test_flush();
      test_debug_port();
      $display("Summary: %0d tests run, %0d errors", tests_run, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule
